// ==== design/bank_arb_pkg.sv ====
package bank_arb_pkg;

    localparam int unsigned RAM_NUM         = 8;
    localparam int unsigned CHANNEL_NUM     = 2;
    localparam int unsigned WR_REQ_NUM      = 4;  // west, east, south, north
    localparam int unsigned CHANNEL_TIMER_W = 10;
    localparam int unsigned RAM_TIMER_W     = 20;

    localparam int unsigned CHAN_BIT_W = $clog2(CHANNEL_TIMER_W);
    localparam int unsigned RAM_BIT_W  = $clog2(RAM_TIMER_W);

    typedef logic [2:0] ram_id_t;  // {block, channel}
    typedef logic [1:0] block_id_t;
    typedef logic [1:0] dir_id_t;
    typedef logic [7:0] tag_t;

    // bit positions inside the busy timers
    typedef logic [CHAN_BIT_W-1:0] chan_bit_t;
    typedef logic [RAM_BIT_W-1:0]  ram_bit_t;

    // cycles from grant until a read reaches its ram
    localparam ram_bit_t RD_BLOCK_DELAY [4] = '{
        ram_bit_t'(1),
        ram_bit_t'(2),
        ram_bit_t'(3),
        ram_bit_t'(4)
    };

    // cycles from channel entry until a write reaches its ram
    localparam ram_bit_t WR_BLOCK_DELAY [4] = '{
        ram_bit_t'(8),
        ram_bit_t'(7),
        ram_bit_t'(6),
        ram_bit_t'(5)
    };

endpackage

// ==== design/bank_arbiter_top.sv ====
module bank_arbiter_top #(
    parameter int unsigned RD_REQ_NUM     = 5,
    parameter int unsigned WR_DELAY_WEST  = 2,
    parameter int unsigned WR_DELAY_EAST  = 3,
    parameter int unsigned WR_DELAY_SOUTH = 6,
    parameter int unsigned WR_DELAY_NORTH = 4
) (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic [RD_REQ_NUM-1:0]                                rd_vld,
    input  bank_arb_pkg::ram_id_t [RD_REQ_NUM-1:0]               rd_ram,
    input  bank_arb_pkg::tag_t [RD_REQ_NUM-1:0]                  rd_tag,
    output logic [RD_REQ_NUM-1:0]                                rd_rdy,
    input  logic [bank_arb_pkg::WR_REQ_NUM-1:0]                  wr_vld,
    input  bank_arb_pkg::ram_id_t [bank_arb_pkg::WR_REQ_NUM-1:0] wr_ram,
    input  bank_arb_pkg::tag_t [bank_arb_pkg::WR_REQ_NUM-1:0]    wr_tag,
    output logic [bank_arb_pkg::WR_REQ_NUM-1:0]                  wr_rdy,
    output logic                                                 grant_vld0,
    output logic                                                 grant_vld1,
    output bank_arb_pkg::ram_id_t                                grant_ram0,
    output bank_arb_pkg::ram_id_t                                grant_ram1,
    output bank_arb_pkg::tag_t                                   grant_tag0,
    output bank_arb_pkg::tag_t                                   grant_tag1,
    output logic                                                 grant_write0,
    output logic                                                 grant_write1,
    input  logic                                                 grant_rdy  // from sram
);

    logic [bank_arb_pkg::RAM_NUM-1:0][bank_arb_pkg::RAM_TIMER_W-1:0]         ram_busy;
    logic [bank_arb_pkg::CHANNEL_NUM-1:0][bank_arb_pkg::CHANNEL_TIMER_W-1:0] chan_busy;
    logic [RD_REQ_NUM-1:0]                                                  rd_ok;
    logic [bank_arb_pkg::WR_REQ_NUM-1:0]                                    wr_ok;
    bank_arb_pkg::dir_id_t                                                  grant_dir0;
    bank_arb_pkg::dir_id_t                                                  grant_dir1;
    logic                                                                   fire0;
    logic                                                                   fire1;

    conflict_timers #(
        .WR_DELAY_WEST  (WR_DELAY_WEST),
        .WR_DELAY_EAST  (WR_DELAY_EAST),
        .WR_DELAY_SOUTH (WR_DELAY_SOUTH),
        .WR_DELAY_NORTH (WR_DELAY_NORTH)
    ) conflict_timers_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .fire0        (fire0),
        .fire1        (fire1),
        .grant_ram0   (grant_ram0),
        .grant_ram1   (grant_ram1),
        .grant_write0 (grant_write0),
        .grant_write1 (grant_write1),
        .grant_dir0   (grant_dir0),
        .grant_dir1   (grant_dir1),
        .ram_busy     (ram_busy),
        .chan_busy    (chan_busy)
    );

    hazard_check #(
        .RD_REQ_NUM     (RD_REQ_NUM),
        .WR_DELAY_WEST  (WR_DELAY_WEST),
        .WR_DELAY_EAST  (WR_DELAY_EAST),
        .WR_DELAY_SOUTH (WR_DELAY_SOUTH),
        .WR_DELAY_NORTH (WR_DELAY_NORTH)
    ) hazard_check_inst (
        .rd_vld    (rd_vld),
        .rd_ram    (rd_ram),
        .wr_vld    (wr_vld),
        .wr_ram    (wr_ram),
        .ram_busy  (ram_busy),
        .chan_busy (chan_busy),
        .rd_ok     (rd_ok),
        .wr_ok     (wr_ok)
    );

    dual_grant_arb #(
        .RD_REQ_NUM (RD_REQ_NUM)
    ) dual_grant_arb_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_ok        (rd_ok),
        .wr_ok        (wr_ok),
        .rd_ram       (rd_ram),
        .rd_tag       (rd_tag),
        .wr_ram       (wr_ram),
        .wr_tag       (wr_tag),
        .grant_rdy    (grant_rdy),
        .rd_rdy       (rd_rdy),
        .wr_rdy       (wr_rdy),
        .grant_vld0   (grant_vld0),
        .grant_vld1   (grant_vld1),
        .grant_ram0   (grant_ram0),
        .grant_ram1   (grant_ram1),
        .grant_tag0   (grant_tag0),
        .grant_tag1   (grant_tag1),
        .grant_write0 (grant_write0),
        .grant_write1 (grant_write1),
        .grant_dir0   (grant_dir0),
        .grant_dir1   (grant_dir1),
        .fire0        (fire0),
        .fire1        (fire1)
    );

endmodule

// ==== design/conflict_timers.sv ====
module conflict_timers #(
    parameter int unsigned WR_DELAY_WEST  = 2,
    parameter int unsigned WR_DELAY_EAST  = 3,
    parameter int unsigned WR_DELAY_SOUTH = 6,
    parameter int unsigned WR_DELAY_NORTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fire0,
    input  logic                  fire1,
    input  bank_arb_pkg::ram_id_t grant_ram0,
    input  bank_arb_pkg::ram_id_t grant_ram1,
    input  logic                  grant_write0,
    input  logic                  grant_write1,
    input  bank_arb_pkg::dir_id_t grant_dir0,
    input  bank_arb_pkg::dir_id_t grant_dir1,
    output logic [bank_arb_pkg::RAM_NUM-1:0][bank_arb_pkg::RAM_TIMER_W-1:0]         ram_busy,
    output logic [bank_arb_pkg::CHANNEL_NUM-1:0][bank_arb_pkg::CHANNEL_TIMER_W-1:0] chan_busy
);

    // channel entry delay per write direction
    localparam bank_arb_pkg::chan_bit_t WR_DELAY [bank_arb_pkg::WR_REQ_NUM] = '{
        bank_arb_pkg::chan_bit_t'(WR_DELAY_WEST),
        bank_arb_pkg::chan_bit_t'(WR_DELAY_EAST),
        bank_arb_pkg::chan_bit_t'(WR_DELAY_SOUTH),
        bank_arb_pkg::chan_bit_t'(WR_DELAY_NORTH)
    };

    logic [1:0]                                                             slot_set;
    bank_arb_pkg::ram_id_t [1:0]                                            slot_ram;
    bank_arb_pkg::dir_id_t [1:0]                                            slot_dir;
    logic [bank_arb_pkg::RAM_NUM-1:0][bank_arb_pkg::RAM_TIMER_W-1:0]         ram_set;
    logic [bank_arb_pkg::CHANNEL_NUM-1:0][bank_arb_pkg::CHANNEL_TIMER_W-1:0] chan_set;

    assign slot_set = {fire1 & grant_write1, fire0 & grant_write0};  // reads leave no mark
    assign slot_ram = {grant_ram1, grant_ram0};
    assign slot_dir = {grant_dir1, grant_dir0};

    // future occupation marks of this cycle's accepted writes
    always_comb begin
        bank_arb_pkg::block_id_t blk;
        bank_arb_pkg::ram_bit_t  ram_bit;
        ram_set  = '0;
        chan_set = '0;
        for (int s = 0; s < 2; s++) begin
            blk     = slot_ram[s][2:1];
            ram_bit = bank_arb_pkg::ram_bit_t'(WR_DELAY[slot_dir[s]])
                      + bank_arb_pkg::WR_BLOCK_DELAY[blk];
            if (slot_set[s]) begin
                chan_set[slot_ram[s][0]][WR_DELAY[slot_dir[s]]] = 1'b1;
                ram_set[slot_ram[s]][ram_bit]                   = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ram_busy  <= '0;
            chan_busy <= '0;
        end else begin
            for (int i = 0; i < bank_arb_pkg::RAM_NUM; i++) begin
                ram_busy[i] <= (ram_busy[i] >> 1) | ram_set[i];  // one cycle closer
            end
            for (int c = 0; c < bank_arb_pkg::CHANNEL_NUM; c++) begin
                chan_busy[c] <= (chan_busy[c] >> 1) | chan_set[c];
            end
        end
    end

endmodule

// ==== design/dual_grant_arb.sv ====
module dual_grant_arb #(
    parameter int unsigned RD_REQ_NUM = 5
) (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic [RD_REQ_NUM-1:0]                                rd_ok,
    input  logic [bank_arb_pkg::WR_REQ_NUM-1:0]                  wr_ok,
    input  bank_arb_pkg::ram_id_t [RD_REQ_NUM-1:0]               rd_ram,
    input  bank_arb_pkg::tag_t [RD_REQ_NUM-1:0]                  rd_tag,
    input  bank_arb_pkg::ram_id_t [bank_arb_pkg::WR_REQ_NUM-1:0] wr_ram,
    input  bank_arb_pkg::tag_t [bank_arb_pkg::WR_REQ_NUM-1:0]    wr_tag,
    input  logic                                                 grant_rdy,
    output logic [RD_REQ_NUM-1:0]                                rd_rdy,
    output logic [bank_arb_pkg::WR_REQ_NUM-1:0]                  wr_rdy,
    output logic                                                 grant_vld0,
    output logic                                                 grant_vld1,
    output bank_arb_pkg::ram_id_t                                grant_ram0,
    output bank_arb_pkg::ram_id_t                                grant_ram1,
    output bank_arb_pkg::tag_t                                   grant_tag0,
    output bank_arb_pkg::tag_t                                   grant_tag1,
    output logic                                                 grant_write0,
    output logic                                                 grant_write1,
    output bank_arb_pkg::dir_id_t                                grant_dir0,
    output bank_arb_pkg::dir_id_t                                grant_dir1,
    output logic                                                 fire0,
    output logic                                                 fire1
);

    localparam int unsigned REQ_NUM = RD_REQ_NUM + bank_arb_pkg::WR_REQ_NUM;
    localparam int unsigned PTR_W   = $clog2(REQ_NUM);

    typedef logic [PTR_W-1:0] req_idx_t;

    logic [REQ_NUM-1:0]                  req_ok;
    logic [REQ_NUM-1:0]                  req_rdy;
    bank_arb_pkg::ram_id_t [REQ_NUM-1:0] req_ram;
    bank_arb_pkg::tag_t [REQ_NUM-1:0]    req_tag;
    req_idx_t                            ptr;
    req_idx_t                            ptr_next;
    req_idx_t                            win0;
    req_idx_t                            win1;
    req_idx_t                            last_win;
    logic                                found0;
    logic                                found1;

    assign req_ok  = {wr_ok, rd_ok};  // reads first, then writes
    assign req_ram = {wr_ram, rd_ram};
    assign req_tag = {wr_tag, rd_tag};

    // cyclic search from the pointer, first two hits win
    always_comb begin
        int unsigned pos;
        req_idx_t    idx;
        found0 = 1'b0;
        found1 = 1'b0;
        win0   = '0;
        win1   = '0;
        for (int unsigned k = 0; k < REQ_NUM; k++) begin
            pos = ptr + k;
            if (pos >= REQ_NUM) begin
                pos = pos - REQ_NUM;
            end
            idx = req_idx_t'(pos);
            if (req_ok[idx]) begin
                if (!found0) begin
                    found0 = 1'b1;
                    win0   = idx;
                end else if (!found1) begin
                    found1 = 1'b1;
                    win1   = idx;
                end
            end
        end
    end

    assign last_win = found1 ? win1 : win0;
    assign ptr_next = (last_win == req_idx_t'(REQ_NUM - 1)) ? '0 : last_win + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (grant_rdy && found0) begin
            ptr <= ptr_next;  // holds under back-pressure
        end
    end

    assign grant_vld0   = found0;
    assign grant_vld1   = found1;
    assign fire0        = found0 & grant_rdy;
    assign fire1        = found1 & grant_rdy;
    assign grant_ram0   = req_ram[win0];
    assign grant_ram1   = req_ram[win1];
    assign grant_tag0   = req_tag[win0];
    assign grant_tag1   = req_tag[win1];
    assign grant_write0 = (win0 >= req_idx_t'(RD_REQ_NUM));
    assign grant_write1 = (win1 >= req_idx_t'(RD_REQ_NUM));
    assign grant_dir0   = grant_write0 ?
                          bank_arb_pkg::dir_id_t'(win0 - req_idx_t'(RD_REQ_NUM)) : '0;
    assign grant_dir1   = grant_write1 ?
                          bank_arb_pkg::dir_id_t'(win1 - req_idx_t'(RD_REQ_NUM)) : '0;

    always_comb begin
        req_rdy = '0;
        if (fire0) begin
            req_rdy[win0] = 1'b1;
        end
        if (fire1) begin
            req_rdy[win1] = 1'b1;
        end
    end

    assign {wr_rdy, rd_rdy} = req_rdy;

endmodule

// ==== design/hazard_check.sv ====
module hazard_check #(
    parameter int unsigned RD_REQ_NUM     = 5,
    parameter int unsigned WR_DELAY_WEST  = 2,
    parameter int unsigned WR_DELAY_EAST  = 3,
    parameter int unsigned WR_DELAY_SOUTH = 6,
    parameter int unsigned WR_DELAY_NORTH = 4
) (
    input  logic [RD_REQ_NUM-1:0]                                rd_vld,
    input  bank_arb_pkg::ram_id_t [RD_REQ_NUM-1:0]               rd_ram,
    input  logic [bank_arb_pkg::WR_REQ_NUM-1:0]                  wr_vld,
    input  bank_arb_pkg::ram_id_t [bank_arb_pkg::WR_REQ_NUM-1:0] wr_ram,
    input  logic [bank_arb_pkg::RAM_NUM-1:0][bank_arb_pkg::RAM_TIMER_W-1:0]         ram_busy,
    input  logic [bank_arb_pkg::CHANNEL_NUM-1:0][bank_arb_pkg::CHANNEL_TIMER_W-1:0] chan_busy,
    output logic [RD_REQ_NUM-1:0]                                rd_ok,
    output logic [bank_arb_pkg::WR_REQ_NUM-1:0]                  wr_ok
);

    // channel entry delay per write direction
    localparam bank_arb_pkg::chan_bit_t WR_DELAY [bank_arb_pkg::WR_REQ_NUM] = '{
        bank_arb_pkg::chan_bit_t'(WR_DELAY_WEST),
        bank_arb_pkg::chan_bit_t'(WR_DELAY_EAST),
        bank_arb_pkg::chan_bit_t'(WR_DELAY_SOUTH),
        bank_arb_pkg::chan_bit_t'(WR_DELAY_NORTH)
    };

    for (genvar i = 0; i < RD_REQ_NUM; i++) begin : g_rd
        bank_arb_pkg::block_id_t blk;
        logic                    chan_free;
        logic                    ram_free;

        assign blk       = rd_ram[i][2:1];
        assign chan_free = ~chan_busy[rd_ram[i][0]][0];  // read is on the channel at once
        assign ram_free  = ~ram_busy[rd_ram[i]][bank_arb_pkg::RD_BLOCK_DELAY[blk]];
        assign rd_ok[i]  = rd_vld[i] & chan_free & ram_free;
    end

    // port index is the direction, so the channel slot is fixed per port
    for (genvar j = 0; j < bank_arb_pkg::WR_REQ_NUM; j++) begin : g_wr
        bank_arb_pkg::block_id_t blk;
        bank_arb_pkg::ram_bit_t  ram_bit;
        logic                    chan_free;
        logic                    ram_free;

        assign blk       = wr_ram[j][2:1];
        assign ram_bit   = bank_arb_pkg::ram_bit_t'(WR_DELAY[j])
                           + bank_arb_pkg::WR_BLOCK_DELAY[blk];
        assign chan_free = ~chan_busy[wr_ram[j][0]][WR_DELAY[j]];
        assign ram_free  = ~ram_busy[wr_ram[j]][ram_bit];
        assign wr_ok[j]  = wr_vld[j] & chan_free & ram_free;
    end

endmodule

// ==== project.f ====
design/bank_arb_pkg.sv
design/conflict_timers.sv
design/hazard_check.sv
design/dual_grant_arb.sv
design/bank_arbiter_top.sv
verification/bank_arbiter_assertions.sv
verification/bank_arbiter_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert --top-module bank_arbiter_tb \
    --Mdir build -o bank_arbiter_sim -f project.f
./build/bank_arbiter_sim 2>&1 | tee sim.log
if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== verification/bank_arbiter_assertions.sv ====
module bank_arbiter_assertions #(
    parameter int unsigned RD_REQ_NUM = 5
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [RD_REQ_NUM-1:0]               rd_vld,
    input  logic [RD_REQ_NUM-1:0]               rd_rdy,
    input  logic [bank_arb_pkg::WR_REQ_NUM-1:0] wr_vld,
    input  logic [bank_arb_pkg::WR_REQ_NUM-1:0] wr_rdy,
    input  logic                                grant_vld0,
    input  logic                                grant_vld1,
    input  logic                                grant_rdy
);

    slot1_needs_slot0: assert property (@(posedge clk) disable iff (!rst_n)
        grant_vld1 |-> grant_vld0)
        else $error("grant slot 1 valid while slot 0 is idle");

    rdy_needs_vld: assert property (@(posedge clk) disable iff (!rst_n)
        ((rd_rdy & ~rd_vld) == '0) && ((wr_rdy & ~wr_vld) == '0))
        else $error("requester rdy returned without a pending vld");

    // sram back-pressure blocks every acceptance
    no_rdy_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        !grant_rdy |-> (rd_rdy == '0) && (wr_rdy == '0))
        else $error("requester rdy returned while grant_rdy is low");

endmodule

bind bank_arbiter_top bank_arbiter_assertions #(
    .RD_REQ_NUM (RD_REQ_NUM)
) bank_arbiter_assertions_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_vld     (rd_vld),
    .rd_rdy     (rd_rdy),
    .wr_vld     (wr_vld),
    .wr_rdy     (wr_rdy),
    .grant_vld0 (grant_vld0),
    .grant_vld1 (grant_vld1),
    .grant_rdy  (grant_rdy)
);

// ==== verification/bank_arbiter_tb.sv ====
module bank_arbiter_tb;

    localparam int RD_N = 5;
    localparam int WR_N = bank_arb_pkg::WR_REQ_NUM;

    logic                             clk;
    logic                             rst_n;
    logic [RD_N-1:0]                  rd_vld;
    bank_arb_pkg::ram_id_t [RD_N-1:0] rd_ram;
    bank_arb_pkg::tag_t [RD_N-1:0]    rd_tag;
    logic [RD_N-1:0]                  rd_rdy;
    logic [WR_N-1:0]                  wr_vld;
    bank_arb_pkg::ram_id_t [WR_N-1:0] wr_ram;
    bank_arb_pkg::tag_t [WR_N-1:0]    wr_tag;
    logic [WR_N-1:0]                  wr_rdy;
    logic                             grant_vld0;
    logic                             grant_vld1;
    bank_arb_pkg::ram_id_t            grant_ram0;
    bank_arb_pkg::ram_id_t            grant_ram1;
    bank_arb_pkg::tag_t               grant_tag0;
    bank_arb_pkg::tag_t               grant_tag1;
    logic                             grant_write0;
    logic                             grant_write1;
    logic                             grant_rdy;

    string       vec_q[$];
    logic [63:0] fld [14];  // test number, 7 inputs, 6 expected outputs
    int          vec_total    = 0;
    int          errors       = 0;
    int          test_errors  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cur_test     = 0;
    int          test_cycles  = 0;
    int          nfld;

    bank_arbiter_top bank_arbiter_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_vld       (rd_vld),
        .rd_ram       (rd_ram),
        .rd_tag       (rd_tag),
        .rd_rdy       (rd_rdy),
        .wr_vld       (wr_vld),
        .wr_ram       (wr_ram),
        .wr_tag       (wr_tag),
        .wr_rdy       (wr_rdy),
        .grant_vld0   (grant_vld0),
        .grant_vld1   (grant_vld1),
        .grant_ram0   (grant_ram0),
        .grant_ram1   (grant_ram1),
        .grant_tag0   (grant_tag0),
        .grant_tag1   (grant_tag1),
        .grant_write0 (grant_write0),
        .grant_write1 (grant_write1),
        .grant_rdy    (grant_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic load_vectors();
        int    fd;
        string line;
        fd = $fopen("verification/bank_arbiter_vectors.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
                vec_q.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error %0t: test %0d %s is %0h, expected %0h",
                     $time, cur_test, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // winner located by its tag among the pending requests
    task automatic check_slot_payload(input string slot, input logic [7:0] exp_tag,
                                      input bank_arb_pkg::ram_id_t got_ram,
                                      input logic got_write);
        int                    hits;
        bank_arb_pkg::ram_id_t exp_ram;
        logic                  exp_write;
        hits      = 0;
        exp_ram   = '0;
        exp_write = 1'b0;
        for (int i = 0; i < RD_N; i++) begin
            if (rd_vld[i] && rd_tag[i] == exp_tag) begin
                hits++;
                exp_ram   = rd_ram[i];
                exp_write = 1'b0;
            end
        end
        for (int j = 0; j < WR_N; j++) begin
            if (wr_vld[j] && wr_tag[j] == exp_tag) begin
                hits++;
                exp_ram   = wr_ram[j];
                exp_write = 1'b1;
            end
        end
        compare_value({slot, " requests with that tag"}, 64'(hits), 64'd1);
        compare_value({slot, " ram"}, 64'(got_ram), 64'(exp_ram));
        compare_value({slot, " write"}, 64'(got_write), 64'(exp_write));
    endtask

    task automatic drive_inputs();
        rd_vld = fld[1][RD_N-1:0];
        for (int i = 0; i < RD_N; i++) begin
            rd_ram[i] = fld[2][4*i +: 3];  // one hex digit per port
        end
        rd_tag = fld[3][8*RD_N-1:0];
        wr_vld = fld[4][WR_N-1:0];
        for (int j = 0; j < WR_N; j++) begin
            wr_ram[j] = fld[5][4*j +: 3];
        end
        wr_tag    = fld[6][8*WR_N-1:0];
        grant_rdy = fld[7][0];
    endtask

    task automatic check_outputs();
        compare_value("grant_vld0", 64'(grant_vld0), 64'(fld[8][0]));
        compare_value("grant_vld1", 64'(grant_vld1), 64'(fld[9][0]));
        if (fld[8][0]) begin
            compare_value("grant_tag0", 64'(grant_tag0), 64'(fld[10][7:0]));
            check_slot_payload("slot 0", fld[10][7:0], grant_ram0, grant_write0);
        end
        if (fld[9][0]) begin
            compare_value("grant_tag1", 64'(grant_tag1), 64'(fld[11][7:0]));
            check_slot_payload("slot 1", fld[11][7:0], grant_ram1, grant_write1);
        end
        compare_value("rd_rdy", 64'(rd_rdy), 64'(fld[12][RD_N-1:0]));
        compare_value("wr_rdy", 64'(wr_rdy), 64'(fld[13][WR_N-1:0]));
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d: %0d cycles, %0s", cur_test, test_cycles,
                 (test_errors == 0) ? "passed" : "failed");
    endtask

    initial begin
        rst_n     = 1'b0;
        rd_vld    = '0;
        rd_ram    = '0;
        rd_tag    = '0;
        wr_vld    = '0;
        wr_ram    = '0;
        wr_tag    = '0;
        grant_rdy = 1'b0;
        load_vectors();
        vec_total = vec_q.size();
        if (vec_total == 0) begin
            $display("no vectors could be read from the vector file");
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (vec_q[n]) begin
            nfld = $sscanf(vec_q[n], "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                           fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13]);
            if (nfld != 14) begin
                $display("vector line %0d could not be parsed", n + 1);
                errors++;
            end else begin
                if (int'(fld[0]) != cur_test) begin
                    if (cur_test != 0) begin
                        close_test();
                    end
                    cur_test    = int'(fld[0]);
                    test_errors = 0;
                    test_cycles = 0;
                end
                @(negedge clk);
                drive_inputs();
                #9;  // just ahead of the rising edge
                check_outputs();
                test_cycles++;
            end
        end
        if (cur_test != 0) begin
            close_test();
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_run != 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog, scaled to the vector count
    initial begin
        wait (vec_total > 0);
        #((vec_total + 16 + 50) * 20);
        $display("timeout: vectors did not finish within %0d cycles", vec_total + 66);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== verification/bank_arbiter_vectors.txt ====
# test rd_vld rd_ram rd_tag wr_vld wr_ram wr_tag grant_rdy vld0 vld1 tag0 tag1 rd_rdy wr_rdy
# all hex; ram fields hold one id digit per port and tag fields one byte, port 0 rightmost
1 00 00000 0000000000 0 0000 00000000 1 0 0 00 00 00 0
2 07 00530 0000121110 0 0000 00000000 1 1 1 10 11 03 0
2 04 00530 0000121110 0 0000 00000000 1 1 0 12 00 04 0
3 00 00000 0000000000 1 0000 00000020 1 1 0 20 00 00 1
3 00 00000 0000000000 0 0000 00000000 1 0 0 00 00 00 0
3 00 00000 0000000000 0 0000 00000000 1 0 0 00 00 00 0
3 00 00000 0000000000 0 0000 00000000 1 0 0 00 00 00 0
3 00 00000 0000000000 0 0000 00000000 1 0 0 00 00 00 0
3 00 00000 0000000000 0 0000 00000000 1 0 0 00 00 00 0
3 00 00000 0000000000 0 0000 00000000 1 0 0 00 00 00 0
3 00 00000 0000000000 0 0000 00000000 1 0 0 00 00 00 0
3 00 00000 0000000000 0 0000 00000000 1 0 0 00 00 00 0
3 00 00000 0000000000 0 0000 00000000 1 0 0 00 00 00 0
3 03 00020 0000003130 0 0000 00000000 1 1 0 31 00 02 0
3 01 00020 0000003130 0 0000 00000000 1 1 0 30 00 01 0
4 00 00000 0000000000 1 0004 00000040 1 1 0 40 00 00 1
4 00 00000 0000000000 0 0000 00000000 1 0 0 00 00 00 0
4 00 00000 0000000000 0 0000 00000000 1 0 0 00 00 00 0
4 03 00016 0000005150 0 0000 00000000 1 1 0 51 00 02 0
4 01 00016 0000005150 0 0000 00000000 1 1 0 50 00 01 0
5 0e 05310 0063626100 0 0000 00000000 0 1 1 61 62 00 0
5 0e 05310 0063626100 0 0000 00000000 0 1 1 61 62 00 0
5 0e 05310 0063626100 0 0000 00000000 1 1 1 61 62 06 0
5 08 05310 0063626100 0 0000 00000000 1 1 0 63 00 08 0
6 00 00000 0000000000 f 6530 73727170 1 1 1 70 71 00 3
6 00 00000 0000000000 c 6530 73727170 1 1 1 72 73 00 c
